// File: verilog.f
src/exu_pkg.sv
src/alu.sv
src/csr_file.sv
src/exu_stage.sv
src/exu_top.sv
tb/exu_properties.sv
tb/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  # rtl in compile order
  - src/exu_pkg.sv
  - src/alu.sv
  - src/csr_file.sv
  - src/exu_stage.sv
  - src/exu_top.sv

  - target: simulation
    files:
      - tb/exu_properties.sv
      - tb/exu_tb.sv

// File: tb/exu_tb.sv
// execute stage testbench
module exu_tb import exu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] mtvec_reset = 32'h8000_0100;
	localparam int clk_period = 20;
	localparam int num_alu = 160;
	localparam int num_branch = 50;
	localparam int num_csr = 15;
	localparam int num_stall = 120;
	localparam int num_pkts = 1 + num_alu + num_branch + num_csr + num_stall;

	logic     clock;
	logic     reset;
	logic     idu_valid_i;
	idu_exu_t idu_pkt_i;
	logic     exu_ready_o;
	logic     exu_valid_o;
	exu_lsu_t exu_pkt_o;
	logic     lsu_ready_i;

	logic [31:0] lfsr_state = 32'd18;
	logic        stall_on;
	logic        exp_valid;
	exu_lsu_t    exp_queue[$];
	int          error_count = 0;
	int          assert_fails;
	int          sent_count = 0;
	int          accepted_count = 0;
	int          transfer_count = 0;

	// csr copy kept by the reference model
	logic [31:0] mstatus_m;
	logic [31:0] mtvec_m;
	logic [31:0] mepc_m;
	logic [31:0] mcause_m;

	exu_top #(
		.MTVEC_RESET (mtvec_reset)
	) DUT (
		.clock       (clock),
		.reset       (reset),
		.idu_valid_i (idu_valid_i),
		.idu_pkt_i   (idu_pkt_i),
		.exu_ready_o (exu_ready_o),
		.exu_valid_o (exu_valid_o),
		.exu_pkt_o   (exu_pkt_o),
		.lsu_ready_i (lsu_ready_i)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic csr_addr_e pick_csr_addr(input logic [1:0] sel);
		case (sel)
			2'd0: return csr_mstatus;
			2'd1: return csr_mtvec;
			2'd2: return csr_mepc;
			default: return csr_mcause;
		endcase
	endfunction

	// plain add of two registers with random data and side fields
	function automatic idu_exu_t random_pkt();
		idu_exu_t p;
		logic [1:0] sel;
		p = '0;
		p.pc = rand_bits(32);
		p.reg1 = rand_bits(32);
		p.reg2 = rand_bits(32);
		p.imm = rand_bits(32);
		p.alu_op = alu_add;
		p.src1_sel = src1_reg1;
		p.src2_sel = src2_reg2;
		p.branch = br_none;
		p.csr_op = csr_none;
		sel = rand_bits(2);
		p.csr_addr = pick_csr_addr(sel);
		p.load_type = rand_bits(3);
		p.store_type = rand_bits(2);
		p.wd = rand_bits(1);
		p.wreg = rand_bits(5);
		p.ebreak = rand_bits(1);
		return p;
	endfunction

	function automatic logic [31:0] csr_model_read(input csr_addr_e addr);
		case (addr)
			csr_mstatus: return mstatus_m;
			csr_mtvec: return mtvec_m;
			csr_mepc: return mepc_m;
			csr_mcause: return mcause_m;
			default: return '0;
		endcase
	endfunction

	// reference model of one instruction
	function automatic exu_lsu_t expected_result(input idu_exu_t p);
		exu_lsu_t r;
		logic [31:0] a;
		logic [31:0] b;
		logic taken;
		r = '0;
		case (p.src1_sel)
			src1_zero: a = '0;
			src1_reg1: a = p.reg1;
			src1_pc: a = p.pc;
			default: a = csr_model_read(p.csr_addr);
		endcase
		case (p.src2_sel)
			src2_zero: b = '0;
			src2_reg2: b = p.reg2;
			src2_imm: b = p.imm;
			default: b = 32'd4;
		endcase
		case (p.alu_op)
			alu_add: r.alu_result = a + b;
			alu_sub: r.alu_result = a - b;
			alu_and: r.alu_result = a & b;
			alu_or: r.alu_result = a | b;
			alu_xor: r.alu_result = a ^ b;
			alu_sll: r.alu_result = a << b[4:0];
			alu_srl: r.alu_result = a >> b[4:0];
			alu_sra: r.alu_result = $signed(a) >>> b[4:0];
			alu_slt: r.alu_result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			alu_sltu: r.alu_result = (a < b) ? 32'd1 : 32'd0;
			default: r.alu_result = '0;
		endcase
		case (p.branch)
			br_beq: taken = (a == b);
			br_bne: taken = (a != b);
			br_blt: taken = ($signed(a) < $signed(b));
			br_bge: taken = !($signed(a) < $signed(b));
			br_bltu: taken = (a < b);
			br_bgeu: taken = !(a < b);
			default: taken = 1'b0;
		endcase
		r.redirect = taken || (p.csr_op == csr_ecall);
		r.redirect_pc = taken ? p.pc + p.imm : mtvec_m;
		r.mem_wdata = p.reg2;
		r.mem_wen = (p.store_type != 2'd0);
		r.load_type = p.load_type;
		r.store_type = p.store_type;
		r.wd = p.wd;
		r.wreg = p.wreg;
		r.ebreak = p.ebreak;
		return r;
	endfunction

	task automatic update_csr_model(input idu_exu_t p);
		logic [31:0] wdata;
		wdata = (p.csr_op == csr_rw) ? p.reg1 : p.reg1 | csr_model_read(p.csr_addr);
		if (p.csr_op == csr_ecall) begin
			mepc_m = p.pc;
			mcause_m = 32'd11;
		end else if (p.csr_op == csr_rw || p.csr_op == csr_rs) begin
			case (p.csr_addr)
				csr_mstatus: mstatus_m = wdata;
				csr_mtvec: mtvec_m = wdata;
				csr_mepc: mepc_m = wdata;
				csr_mcause: mcause_m = wdata;
				default: begin
				end
			endcase
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error at %0d ns: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic compare_pkt(input exu_lsu_t e, input exu_lsu_t a);
		check_value("exu_pkt_o.alu_result", e.alu_result, a.alu_result);
		check_value("exu_pkt_o.mem_wdata", e.mem_wdata, a.mem_wdata);
		check_value("exu_pkt_o.redirect", e.redirect, a.redirect);
		// target only matters when a redirect is raised
		if (e.redirect) begin
			check_value("exu_pkt_o.redirect_pc", e.redirect_pc, a.redirect_pc);
		end
		check_value("exu_pkt_o.mem_wen", e.mem_wen, a.mem_wen);
		check_value("exu_pkt_o.load_type", e.load_type, a.load_type);
		check_value("exu_pkt_o.store_type", e.store_type, a.store_type);
		check_value("exu_pkt_o.wd", e.wd, a.wd);
		check_value("exu_pkt_o.wreg", e.wreg, a.wreg);
		check_value("exu_pkt_o.ebreak", e.ebreak, a.ebreak);
	endtask

	task automatic drive_lsu_ready();
		if (stall_on) begin
			lsu_ready_i <= (rand_bits(2) != 0);
		end else begin
			lsu_ready_i <= 1'b1;
		end
	endtask

	task automatic idle_cycle();
		idu_valid_i <= 1'b0;
		drive_lsu_ready();
		@(posedge clock);
	endtask

	// holds the packet until the edge that accepts it
	task automatic send_pkt(input idu_exu_t p);
		logic done;
		idu_valid_i <= 1'b1;
		idu_pkt_i <= p;
		drive_lsu_ready();
		done = 1'b0;
		while (!done) begin
			@(negedge clock);
			done = exu_ready_o;
			@(posedge clock);
			if (!done) begin
				drive_lsu_ready();
			end
		end
		sent_count++;
	endtask

	// accept capture, computes the expected packet before the csr update
	always @(negedge clock) begin
		if (reset) begin
			mstatus_m = '0;
			mtvec_m = mtvec_reset;
			mepc_m = '0;
			mcause_m = '0;
		end else if (idu_valid_i && exu_ready_o) begin
			exp_queue.push_back(expected_result(idu_pkt_i));
			update_csr_model(idu_pkt_i);
			accepted_count++;
		end
	end

	// compare process
	always @(negedge clock) begin
		if (reset) begin
			exp_valid = 1'b0;
		end else begin
			check_value("exu_valid_o", exp_valid, exu_valid_o);
			check_value("exu_ready_o", !exp_valid || lsu_ready_i, exu_ready_o);
			if (exu_valid_o && lsu_ready_i) begin
				transfer_count++;
				if (exp_queue.size() == 0) begin
					$display("output transfer at %0d ns with no packet outstanding", $time);
					error_count++;
				end else begin
					compare_pkt(exp_queue.pop_front(), exu_pkt_o);
				end
			end
			exp_valid = (idu_valid_i && exu_ready_o) || (exp_valid && !lsu_ready_i);
		end
	end

	initial begin
		#((num_pkts * 40 + 100) * clk_period);
		$display("timeout: the stage stopped moving packets");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		idu_exu_t p;
		idu_valid_i = 1'b0;
		idu_pkt_i = '0;
		lsu_ready_i = 1'b1;
		stall_on = 1'b0;
		reset = 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		repeat (4) idle_cycle();

		// mtvec reset value read back through csrrs with zero
		p = random_pkt();
		p.csr_op = csr_rs;
		p.csr_addr = csr_mtvec;
		p.reg1 = '0;
		p.src1_sel = src1_csr;
		p.src2_sel = src2_zero;
		send_pkt(p);

		// every opcode against every source pair
		for (int op = 0; op < 10; op++) begin
			for (int s1 = 0; s1 < 4; s1++) begin
				for (int s2 = 0; s2 < 4; s2++) begin
					p = random_pkt();
					p.alu_op = alu_op_e'(op);
					p.src1_sel = src1_sel_e'(s1);
					p.src2_sel = src2_sel_e'(s2);
					send_pkt(p);
				end
			end
		end

		// branch kinds, second half with equal operands
		for (int k = 1; k <= 6; k++) begin
			for (int t = 0; t < 8; t++) begin
				p = random_pkt();
				p.branch = branch_e'(k);
				if (k <= 2) begin
					p.alu_op = alu_sub;
				end else if (k <= 4) begin
					p.alu_op = alu_slt;
				end else begin
					p.alu_op = alu_sltu;
				end
				if (t >= 4) begin
					p.reg2 = p.reg1;
				end
				send_pkt(p);
			end
		end
		for (int t = 0; t < 2; t++) begin
			p = random_pkt();
			p.alu_op = alu_sub;
			p.reg2 = p.reg1;
			send_pkt(p);
		end

		// csrrw, csrrs, then read back on each csr
		for (int i = 0; i < 4; i++) begin
			p = random_pkt();
			p.csr_addr = pick_csr_addr(i[1:0]);
			p.src1_sel = src1_csr;
			p.src2_sel = src2_zero;
			p.csr_op = csr_rw;
			send_pkt(p);
			p.csr_op = csr_rs;
			p.reg1 = rand_bits(32);
			send_pkt(p);
			p.reg1 = '0;
			send_pkt(p);
		end

		// ecall then mepc and mcause
		p = random_pkt();
		p.csr_op = csr_ecall;
		send_pkt(p);
		p.csr_op = csr_rs;
		p.reg1 = '0;
		p.src1_sel = src1_csr;
		p.src2_sel = src2_zero;
		p.csr_addr = csr_mepc;
		send_pkt(p);
		p.csr_addr = csr_mcause;
		send_pkt(p);

		// mixed traffic with lsu stalls and input gaps
		stall_on = 1'b1;
		for (int n = 0; n < num_stall; n++) begin
			p = random_pkt();
			p.alu_op = alu_op_e'(rand_bits(4) % 10);
			p.src1_sel = src1_sel_e'(rand_bits(2));
			p.src2_sel = src2_sel_e'(rand_bits(2));
			p.csr_op = csr_op_e'(rand_bits(2));
			send_pkt(p);
			if (rand_bits(2) == 0) begin
				idle_cycle();
			end
		end

		stall_on = 1'b0;
		idu_valid_i <= 1'b0;
		lsu_ready_i <= 1'b1;
		while (exp_queue.size() != 0) begin
			@(posedge clock);
		end
		repeat (3) @(posedge clock);

		check_value("accepted packets", sent_count, accepted_count);
		check_value("delivered packets", accepted_count, transfer_count);
		assert_fails = DUT.u_stage.u_props.fail_count;
		$display("errors: %0d value, %0d assertion", error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: tb/exu_properties.sv
// execute stage handshake assertions
module exu_properties import exu_pkg::*; (
	input logic     clock,
	input logic     reset,
	input logic     exu_valid_o,
	input logic     exu_ready_o,
	input logic     lsu_ready_i,
	input exu_lsu_t exu_pkt_o
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// a stalled packet stays put until the lsu takes it
	hold_stable: assert property (@(posedge clock) disable iff (reset)
		exu_valid_o && !lsu_ready_i |=> exu_valid_o && $stable(exu_pkt_o))
	else begin
		$error("output packet or valid changed while the lsu stalled");
		fail_count++;
	end

	valid_after_reset: assert property (@(posedge clock)
		reset |=> !exu_valid_o)
	else begin
		$error("output valid high in the cycle after reset");
		fail_count++;
	end

	// empty output register takes the next packet straight away
	ready_when_empty: assert property (@(posedge clock) disable iff (reset)
		!exu_valid_o |-> exu_ready_o ##1 (exu_valid_o == $past(idu_valid_seen)))
	else begin
		$error("empty stage not ready or did not take the offered packet");
		fail_count++;
	end

	logic idu_valid_seen;
	assign idu_valid_seen = exu_stage.idu_valid_i;

endmodule

bind exu_stage exu_properties u_props (
	.clock       (clock),
	.reset       (reset),
	.exu_valid_o (exu_valid_o),
	.exu_ready_o (exu_ready_o),
	.lsu_ready_i (lsu_ready_i),
	.exu_pkt_o   (exu_pkt_o)
);

// File: src/exu_top.sv
// execute stage top level
module exu_top import exu_pkg::*; #(
	parameter logic [xlen-1:0] MTVEC_RESET = 32'h8000_0000
) (
	input  logic     clock,
	input  logic     reset,
	input  logic     idu_valid_i,
	input  idu_exu_t idu_pkt_i,
	output logic     exu_ready_o,
	output logic     exu_valid_o,
	output exu_lsu_t exu_pkt_o,
	input  logic     lsu_ready_i
);

	alu_op_e         alu_op;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] alu_result;
	logic            alu_zero;
	logic            alu_less;
	logic            csr_commit;
	csr_op_e         csr_op;
	csr_addr_e       csr_addr;
	logic [xlen-1:0] csr_wdata;
	logic [xlen-1:0] csr_pc;
	logic [xlen-1:0] csr_rdata;
	logic [xlen-1:0] mtvec;

	exu_stage u_stage (
		.clock        (clock),
		.reset        (reset),
		.idu_valid_i  (idu_valid_i),
		.idu_pkt_i    (idu_pkt_i),
		.exu_ready_o  (exu_ready_o),
		.exu_valid_o  (exu_valid_o),
		.exu_pkt_o    (exu_pkt_o),
		.lsu_ready_i  (lsu_ready_i),
		.alu_op_o     (alu_op),
		.src1_o       (src1),
		.src2_o       (src2),
		.alu_result_i (alu_result),
		.alu_zero_i   (alu_zero),
		.alu_less_i   (alu_less),
		.csr_commit_o (csr_commit),
		.csr_op_o     (csr_op),
		.csr_addr_o   (csr_addr),
		.csr_wdata_o  (csr_wdata),
		.csr_pc_o     (csr_pc),
		.csr_rdata_i  (csr_rdata),
		.mtvec_i      (mtvec)
	);

	alu u_alu (
		.alu_op_i (alu_op),
		.src1_i   (src1),
		.src2_i   (src2),
		.result_o (alu_result),
		.zero_o   (alu_zero),
		.less_o   (alu_less)
	);

	csr_file #(
		.MTVEC_RESET (MTVEC_RESET)
	) u_csr (
		.clock       (clock),
		.reset       (reset),
		.commit_i    (csr_commit),
		.csr_op_i    (csr_op),
		.csr_addr_i  (csr_addr),
		.csr_wdata_i (csr_wdata),
		.pc_i        (csr_pc),
		.csr_rdata_o (csr_rdata),
		.mtvec_o     (mtvec)
	);

endmodule

// File: src/exu_stage.sv
// execute stage with registered output
module exu_stage import exu_pkg::*; (
	input  logic            clock,
	input  logic            reset,

	// decoder side
	input  logic            idu_valid_i,
	input  idu_exu_t        idu_pkt_i,
	output logic            exu_ready_o,

	// load/store side
	output logic            exu_valid_o,
	output exu_lsu_t        exu_pkt_o,
	input  logic            lsu_ready_i,

	// alu
	output alu_op_e         alu_op_o,
	output logic [xlen-1:0] src1_o,
	output logic [xlen-1:0] src2_o,
	input  logic [xlen-1:0] alu_result_i,
	input  logic            alu_zero_i,
	input  logic            alu_less_i,

	// csr block
	output logic            csr_commit_o,
	output csr_op_e         csr_op_o,
	output csr_addr_e       csr_addr_o,
	output logic [xlen-1:0] csr_wdata_o,
	output logic [xlen-1:0] csr_pc_o,
	input  logic [xlen-1:0] csr_rdata_i,
	input  logic [xlen-1:0] mtvec_i
);

	// run: output register empty, hold: packet waits for lsu
	typedef enum logic {
		st_run  = 1'b0,
		st_hold = 1'b1
	} state_e;

	state_e   state_q;
	state_e   state_d;
	exu_lsu_t pkt_q;
	exu_lsu_t pkt_d;
	logic     accept;
	logic     taken;

	always_comb begin
		case (idu_pkt_i.src1_sel)
			src1_zero: src1_o = '0;
			src1_reg1: src1_o = idu_pkt_i.reg1;
			src1_pc:   src1_o = idu_pkt_i.pc;
			src1_csr:  src1_o = csr_rdata_i;
			default:   src1_o = '0;
		endcase
	end

	always_comb begin
		case (idu_pkt_i.src2_sel)
			src2_zero: src2_o = '0;
			src2_reg2: src2_o = idu_pkt_i.reg2;
			src2_imm:  src2_o = idu_pkt_i.imm;
			src2_four: src2_o = 32'd4;
			default:   src2_o = '0;
		endcase
	end

	assign alu_op_o = idu_pkt_i.alu_op;

	// decoder picks sub, slt or sltu to match the branch kind
	always_comb begin
		case (idu_pkt_i.branch)
			br_beq:  taken = alu_zero_i;
			br_bne:  taken = !alu_zero_i;
			br_blt:  taken = alu_less_i;
			br_bge:  taken = !alu_less_i;
			br_bltu: taken = alu_less_i;
			br_bgeu: taken = !alu_less_i;
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		case (idu_pkt_i.csr_op)
			csr_rw:  csr_wdata_o = idu_pkt_i.reg1;
			csr_rs:  csr_wdata_o = idu_pkt_i.reg1 | csr_rdata_i;
			default: csr_wdata_o = '0;
		endcase
	end

	assign exu_ready_o = (state_q == st_run) || lsu_ready_i;
	assign accept = idu_valid_i && exu_ready_o;

	// csr side effects land on the accept edge
	assign csr_commit_o = accept;
	assign csr_op_o = idu_pkt_i.csr_op;
	assign csr_addr_o = idu_pkt_i.csr_addr;
	assign csr_pc_o = idu_pkt_i.pc;

	always_comb begin
		pkt_d.alu_result  = alu_result_i;
		pkt_d.mem_wdata   = idu_pkt_i.reg2;
		pkt_d.redirect    = taken || (idu_pkt_i.csr_op == csr_ecall);
		pkt_d.redirect_pc = taken ? idu_pkt_i.pc + idu_pkt_i.imm : mtvec_i;
		pkt_d.mem_wen     = |idu_pkt_i.store_type;
		pkt_d.load_type   = idu_pkt_i.load_type;
		pkt_d.store_type  = idu_pkt_i.store_type;
		pkt_d.wd          = idu_pkt_i.wd;
		pkt_d.wreg        = idu_pkt_i.wreg;
		pkt_d.ebreak      = idu_pkt_i.ebreak;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			st_run: begin
				if (idu_valid_i) begin
					state_d = st_hold;
				end
			end
			st_hold: begin
				// drains only when nothing new replaces it
				if (lsu_ready_i && !idu_valid_i) begin
					state_d = st_run;
				end
			end
			default: begin
				state_d = st_run;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= st_run;
		end else begin
			state_q <= state_d;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			pkt_q <= pkt_d;
		end
	end

	assign exu_valid_o = (state_q == st_hold);
	assign exu_pkt_o = pkt_q;

endmodule

// File: src/csr_file.sv
// machine mode csr registers
module csr_file import exu_pkg::*; #(
	parameter logic [xlen-1:0] MTVEC_RESET = 32'h8000_0000
) (
	input  logic            clock,
	input  logic            reset,
	input  logic            commit_i,
	input  csr_op_e         csr_op_i,
	input  csr_addr_e       csr_addr_i,
	input  logic [xlen-1:0] csr_wdata_i,
	input  logic [xlen-1:0] pc_i,
	output logic [xlen-1:0] csr_rdata_o,
	output logic [xlen-1:0] mtvec_o
);

	logic [xlen-1:0] mstatus_q;
	logic [xlen-1:0] mtvec_q;
	logic [xlen-1:0] mepc_q;
	logic [xlen-1:0] mcause_q;
	logic            csr_write;
	logic            ecall;

	assign csr_write = commit_i && (csr_op_i == csr_rw || csr_op_i == csr_rs);
	assign ecall = commit_i && (csr_op_i == csr_ecall);

	// unknown addresses read as zero
	always_comb begin
		case (csr_addr_i)
			csr_mstatus: csr_rdata_o = mstatus_q;
			csr_mtvec:   csr_rdata_o = mtvec_q;
			csr_mepc:    csr_rdata_o = mepc_q;
			csr_mcause:  csr_rdata_o = mcause_q;
			default:     csr_rdata_o = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mstatus_q <= '0;
			mtvec_q   <= MTVEC_RESET;
			mepc_q    <= '0;
			mcause_q  <= '0;
		end else if (ecall) begin
			// trap entry, save the faulting pc
			mepc_q   <= pc_i;
			mcause_q <= mcause_ecall;
		end else if (csr_write) begin
			case (csr_addr_i)
				csr_mstatus: mstatus_q <= csr_wdata_i;
				csr_mtvec:   mtvec_q   <= csr_wdata_i;
				csr_mepc:    mepc_q    <= csr_wdata_i;
				csr_mcause:  mcause_q  <= csr_wdata_i;
				default: begin
				end
			endcase
		end
	end

	// trap vector for the stage redirect
	assign mtvec_o = mtvec_q;

endmodule

// File: src/alu.sv
// rv32 integer alu
module alu import exu_pkg::*; (
	input  alu_op_e         alu_op_i,
	input  logic [xlen-1:0] src1_i,
	input  logic [xlen-1:0] src2_i,
	output logic [xlen-1:0] result_o,
	output logic            zero_o,
	output logic            less_o
);

	logic [4:0] shamt;
	logic       signed_lt;
	logic       unsigned_lt;

	assign shamt = src2_i[4:0];
	assign signed_lt = $signed(src1_i) < $signed(src2_i);
	assign unsigned_lt = src1_i < src2_i;

	always_comb begin
		case (alu_op_i)
			alu_add: begin
				result_o = src1_i + src2_i;
			end
			alu_sub: begin
				result_o = src1_i - src2_i;
			end
			alu_and: begin
				result_o = src1_i & src2_i;
			end
			alu_or: begin
				result_o = src1_i | src2_i;
			end
			alu_xor: begin
				result_o = src1_i ^ src2_i;
			end
			alu_sll: begin
				result_o = src1_i << shamt;
			end
			alu_srl: begin
				result_o = src1_i >> shamt;
			end
			alu_sra: begin
				result_o = $unsigned($signed(src1_i) >>> shamt);
			end
			alu_slt: begin
				result_o = {{(xlen-1){1'b0}}, signed_lt};
			end
			alu_sltu: begin
				result_o = {{(xlen-1){1'b0}}, unsigned_lt};
			end
			default: begin
				result_o = '0;
			end
		endcase
	end

	assign zero_o = (result_o == '0);

	// compare ops report their own bit, everything else signed
	always_comb begin
		case (alu_op_i)
			alu_slt, alu_sltu: begin
				less_o = result_o[0];
			end
			default: begin
				less_o = signed_lt;
			end
		endcase
	end

endmodule

// File: src/exu_pkg.sv
// execute stage shared types
package exu_pkg;

	parameter int xlen = 32;

	// alu operation selected by the decoder
	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_and  = 4'd2,
		alu_or   = 4'd3,
		alu_xor  = 4'd4,
		alu_sll  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_slt  = 4'd8,
		alu_sltu = 4'd9
	} alu_op_e;

	typedef enum logic [1:0] {
		src1_zero = 2'd0,
		src1_reg1 = 2'd1,
		src1_pc   = 2'd2,
		src1_csr  = 2'd3
	} src1_sel_e;

	typedef enum logic [1:0] {
		src2_zero = 2'd0,
		src2_reg2 = 2'd1,
		src2_imm  = 2'd2,
		src2_four = 2'd3
	} src2_sel_e;

	typedef enum logic [2:0] {
		br_none = 3'd0,
		br_beq  = 3'd1,
		br_bne  = 3'd2,
		br_blt  = 3'd3,
		br_bge  = 3'd4,
		br_bltu = 3'd5,
		br_bgeu = 3'd6
	} branch_e;

	typedef enum logic [1:0] {
		csr_none  = 2'd0,
		csr_rw    = 2'd1,
		csr_rs    = 2'd2,
		csr_ecall = 2'd3
	} csr_op_e;

	// machine mode csrs implemented here
	typedef enum logic [11:0] {
		csr_mstatus = 12'h300,
		csr_mtvec   = 12'h305,
		csr_mepc    = 12'h341,
		csr_mcause  = 12'h342
	} csr_addr_e;

	// environment call from m-mode
	parameter logic [xlen-1:0] mcause_ecall = 32'd11;

	// decoder to execute
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] reg1;
		logic [xlen-1:0] reg2;
		logic [xlen-1:0] imm;
		alu_op_e         alu_op;
		src1_sel_e       src1_sel;
		src2_sel_e       src2_sel;
		branch_e         branch;
		csr_op_e         csr_op;
		csr_addr_e       csr_addr;
		logic [2:0]      load_type;
		logic [1:0]      store_type;
		logic            wd;
		logic [4:0]      wreg;
		logic            ebreak;
	} idu_exu_t;

	// execute to load/store unit
	typedef struct packed {
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] mem_wdata;
		logic [xlen-1:0] redirect_pc;
		logic            redirect;
		logic            mem_wen;
		logic [2:0]      load_type;
		logic [1:0]      store_type;
		logic            wd;
		logic [4:0]      wreg;
		logic            ebreak;
	} exu_lsu_t;

endpackage
